/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= vectorTb
FLIST     ?= flist.f
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

clean:
	rm -rf obj_dir

/* flist.f */
hdl/vectorPkg.sv
hdl/clockEnables.sv
hdl/lineQueue.sv
hdl/lineRasterizer.sv
hdl/vectorTop.sv
testbench/vectorTop_chk.sv
testbench/vectorChecker.sv
testbench/vectorTb.sv

/* hdl/clockEnables.sv */
module clockEnables #(
  parameter int clkDiv = 8,
  parameter int nmiDiv = 224
) (
  input  logic clk,
  input  logic rst,
  output logic drawEn,
  output logic nmi
);

  // Keep at least one bit when a divisor is 1
  localparam int drawCntW = (clkDiv > 1) ? $clog2(clkDiv) : 1;
  localparam int nmiCntW  = (nmiDiv > 1) ? $clog2(nmiDiv) : 1;

  logic [drawCntW-1:0] drawCnt;
  logic [nmiCntW-1:0]  nmiCnt;
  logic                drawWrap;
  logic                nmiWrap;

  assign drawWrap = (drawCnt == drawCntW'(clkDiv - 1));
  assign nmiWrap  = (nmiCnt == nmiCntW'(nmiDiv - 1));

  // Draw step strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      drawCnt <= '0;
      drawEn  <= 1'b0;
    end else begin
      drawEn  <= drawWrap;
      drawCnt <= drawWrap ? '0 : drawCnt + 1'b1;
    end
  end

  // Periodic NMI with the first pulse one full period after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      nmiCnt <= '0;
      nmi    <= 1'b0;
    end else begin
      nmi    <= nmiWrap;
      nmiCnt <= nmiWrap ? '0 : nmiCnt + 1'b1;
    end
  end

endmodule

/* hdl/lineQueue.sv */
module lineQueue #(
  parameter int  queueDepth = 4,
  parameter type payloadT   = vectorPkg::lineSeg
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    write,
  input  logic    read,
  input  payloadT dataIn,
  output payloadT dataOut,
  output logic    full,
  output logic    empty
);

  localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
  localparam int cntW = $clog2(queueDepth + 1);

  payloadT         entries [queueDepth];
  logic [ptrW-1:0] rdPtr;
  logic [ptrW-1:0] wrPtr;
  logic [cntW-1:0] count;
  logic            doWrite;
  logic            doRead;

  // Wrap explicitly so any depth works, not only powers of two
  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
    if (ptr == ptrW'(queueDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full    = (count == cntW'(queueDepth));
  assign empty   = (count == '0);
  assign doWrite = write && !full;
  assign doRead  = read && !empty;

  // Head entry is always visible
  assign dataOut = entries[rdPtr];

  always_ff @(posedge clk) begin
    if (rst) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doRead) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (doWrite) begin
      entries[wrPtr] <= dataIn;
    end
  end

endmodule

/* hdl/lineRasterizer.sv */
module lineRasterizer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 drawEn,
  input  logic                 empty,
  input  vectorPkg::lineSeg    seg,
  output logic                 read,
  output logic                 pixelValid,
  output logic                 lineDone,
  output vectorPkg::pixelWrite pixel
);

  // Headroom for the doubled error term
  localparam int errW  = vectorPkg::coordW + 3;
  localparam int addrW = vectorPkg::fbAddrW;

  typedef enum logic {
    stIdle,
    stDrawing
  } rastStateT;

  rastStateT              state;
  vectorPkg::coordT       curX;
  vectorPkg::coordT       curY;
  vectorPkg::coordT       endX;
  vectorPkg::coordT       endY;
  logic signed [1:0]      stepX;
  logic signed [1:0]      stepY;
  logic signed [errW-1:0] dx;
  logic signed [errW-1:0] dy;
  logic signed [errW-1:0] err;
  logic [3:0]             color;

  logic signed [errW-1:0] diffX;
  logic signed [errW-1:0] diffY;
  logic signed [errW-1:0] err2;
  logic signed [errW-1:0] errNext;
  vectorPkg::coordT       nextX;
  vectorPkg::coordT       nextY;
  logic                   onScreen;
  logic                   lastPoint;
  logic [addrW-1:0]       pointAddr;

  // Pull the head segment whenever idle and something is queued
  assign read = (state == stIdle) && !empty;

  assign diffX = errW'(seg.endX) - errW'(seg.startX);
  assign diffY = errW'(seg.endY) - errW'(seg.startY);

  //////////////////////////////
  // Bresenham step
  //////////////////////////////

  always_comb begin
    err2    = err <<< 1;
    errNext = err;
    nextX   = curX;
    nextY   = curY;
    if (err2 >= -dy) begin
      errNext = errNext - dy;
      nextX   = curX + vectorPkg::coordT'(stepX);
    end
    if (err2 <= dx) begin
      errNext = errNext + dx;
      nextY   = curY + vectorPkg::coordT'(stepY);
    end
  end

  assign lastPoint = (curX == endX) && (curY == endY);

  // Clip against the visible raster
  assign onScreen = (curX >= 0) && (curX < vectorPkg::screenW) &&
                    (curY >= 0) && (curY < vectorPkg::screenH);

  assign pointAddr = addrW'(curY) * addrW'(vectorPkg::screenW) + addrW'(curX);

  //////////////////////////////
  // Control
  //////////////////////////////

  // lineDone holds for one cycle in drawing, then back to idle
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= stIdle;
      pixelValid <= 1'b0;
      lineDone   <= 1'b0;
    end else begin
      pixelValid <= 1'b0;
      lineDone   <= 1'b0;
      case (state)
        stIdle: begin
          if (read) begin
            state <= stDrawing;
          end
        end
        stDrawing: begin
          if (lineDone) begin
            state <= stIdle;
          end else if (drawEn) begin
            pixelValid <= onScreen;
            lineDone   <= lastPoint;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (read) begin
      curX  <= seg.startX;
      curY  <= seg.startY;
      endX  <= seg.endX;
      endY  <= seg.endY;
      color <= seg.intensity;
      dx    <= diffX[errW-1] ? -diffX : diffX;
      dy    <= diffY[errW-1] ? -diffY : diffY;
      stepX <= diffX[errW-1] ? -2'sd1 : 2'sd1;
      stepY <= diffY[errW-1] ? -2'sd1 : 2'sd1;
      err   <= (diffX[errW-1] ? -diffX : diffX) - (diffY[errW-1] ? -diffY : diffY);
    end else if ((state == stDrawing) && drawEn && !lineDone) begin
      pixel <= '{x: curX, y: curY, addr: pointAddr, color: color};
      curX  <= nextX;
      curY  <= nextY;
      err   <= errNext;
    end
  end

endmodule

/* hdl/vectorPkg.sv */
package vectorPkg;

  //////////////////////////////
  // Screen geometry
  //////////////////////////////

  // Signed so endpoints may sit off screen and get clipped
  localparam int coordW = 13;

  localparam int screenW = 640;
  localparam int screenH = 480;

  // 640 x 480 needs 19 bits of linear address
  localparam int fbAddrW = 19;

  typedef logic signed [coordW-1:0] coordT;

  //////////////////////////////
  // Vector and pixel records
  //////////////////////////////

  // One queued vector from the vector generator
  typedef struct packed {
    coordT      startX;
    coordT      startY;
    coordT      endX;
    coordT      endY;
    logic [3:0] intensity;
  } lineSeg;

  // One framebuffer write
  typedef struct packed {
    coordT              x;
    coordT              y;
    logic [fbAddrW-1:0] addr;
    logic [3:0]         color;
  } pixelWrite;

endpackage

/* hdl/vectorTop.sv */
module vectorTop #(
  parameter int clkDiv     = 8,
  parameter int nmiDiv     = 224,
  parameter int queueDepth = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lrWrite,
  input  vectorPkg::lineSeg    segIn,
  output logic                 queueFull,
  output logic                 pixelValid,
  output logic                 lineDone,
  output logic                 nmi,
  output vectorPkg::pixelWrite pixelOut
);

  logic              drawEn;
  logic              queueEmpty;
  logic              queueRead;
  vectorPkg::lineSeg headSeg;

  clockEnables #(
    .clkDiv (clkDiv),
    .nmiDiv (nmiDiv)
  ) clockEnables_inst (
    .clk    (clk),
    .rst    (rst),
    .drawEn (drawEn),
    .nmi    (nmi)
  );

  // Line register queue between the vector generator and the rasterizer
  lineQueue #(
    .queueDepth (queueDepth),
    .payloadT   (vectorPkg::lineSeg)
  ) lineQueue_inst (
    .clk     (clk),
    .rst     (rst),
    .write   (lrWrite),
    .read    (queueRead),
    .dataIn  (segIn),
    .dataOut (headSeg),
    .full    (queueFull),
    .empty   (queueEmpty)
  );

  lineRasterizer lineRasterizer_inst (
    .clk        (clk),
    .rst        (rst),
    .drawEn     (drawEn),
    .empty      (queueEmpty),
    .seg        (headSeg),
    .read       (queueRead),
    .pixelValid (pixelValid),
    .lineDone   (lineDone),
    .pixel      (pixelOut)
  );

endmodule

/* testbench/vectorChecker.sv */
module vectorChecker #(
  parameter int nmiDiv = 224
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lrWrite,
  input  vectorPkg::lineSeg    segIn,
  input  int                   expPixels,
  input  logic                 queueFull,
  input  logic                 pixelValid,
  input  vectorPkg::pixelWrite pixelOut,
  input  logic                 lineDone,
  input  logic                 nmi,
  output int                   passCount,
  output int                   failCount,
  output int                   doneSegs,
  output int                   pendingSegs
);

  localparam int addrW = vectorPkg::fbAddrW;

  vectorPkg::lineSeg    segQ [$];
  int                   expQ [$];
  vectorPkg::pixelWrite gotQ [$];
  vectorPkg::pixelWrite refQ [$];
  int                   cycleNo;
  int                   lastNmi;

  function automatic int compareValue(string name, int expVal, int gotVal);
    if (expVal == gotVal) begin
      return 0;
    end
    $display("mismatch time=%0t signal=%s expected=%0d got=%0d", $time, name, expVal, gotVal);
    return 1;
  endfunction

  //////////////////////////////
  // Reference line walk
  //////////////////////////////

  task automatic buildReference(input vectorPkg::lineSeg s);
    vectorPkg::pixelWrite p;
    int x;
    int y;
    int dx;
    int dy;
    int sx;
    int sy;
    int err;
    int e2;
    logic atEnd;
    x  = int'(s.startX);
    y  = int'(s.startY);
    dx = (int'(s.endX) > x) ? int'(s.endX) - x : x - int'(s.endX);
    dy = (int'(s.endY) > y) ? int'(s.endY) - y : y - int'(s.endY);
    sx = (int'(s.endX) >= x) ? 1 : -1;
    sy = (int'(s.endY) >= y) ? 1 : -1;
    err   = dx - dy;
    atEnd = 1'b0;
    refQ.delete();
    while (!atEnd) begin
      if (x >= 0 && x < vectorPkg::screenW && y >= 0 && y < vectorPkg::screenH) begin
        p.x     = vectorPkg::coordT'(x);
        p.y     = vectorPkg::coordT'(y);
        p.addr  = addrW'(y * vectorPkg::screenW + x);
        p.color = s.intensity;
        refQ.push_back(p);
      end
      atEnd = (x == int'(s.endX)) && (y == int'(s.endY));
      e2 = 2 * err;
      if (e2 >= -dy) begin
        err = err - dy;
        x   = x + sx;
      end
      if (e2 <= dx) begin
        err = err + dx;
        y   = y + sy;
      end
    end
  endtask

  task automatic checkSegment(input vectorPkg::lineSeg s, input int expCount,
                              input logic lastValid);
    int errs;
    int n;
    logic endOn;
    errs = 0;
    buildReference(s);
    // The end point is written together with lineDone when it is on screen
    endOn = (int'(s.endX) >= 0) && (int'(s.endX) < vectorPkg::screenW) &&
            (int'(s.endY) >= 0) && (int'(s.endY) < vectorPkg::screenH);
    errs += compareValue("pixelValid at lineDone", int'(endOn), int'(lastValid));
    if (expCount >= 0) begin
      errs += compareValue("pixel count", expCount, gotQ.size());
    end
    errs += compareValue("pixel count", refQ.size(), gotQ.size());
    n = (refQ.size() < gotQ.size()) ? refQ.size() : gotQ.size();
    for (int i = 0; i < n; i++) begin
      errs += compareValue("pixelOut.x", int'(refQ[i].x), int'(gotQ[i].x));
      errs += compareValue("pixelOut.y", int'(refQ[i].y), int'(gotQ[i].y));
      errs += compareValue("pixelOut.addr", int'(refQ[i].addr), int'(gotQ[i].addr));
      errs += compareValue("pixelOut.color", int'(refQ[i].color), int'(gotQ[i].color));
    end
    doneSegs++;
    if (errs == 0) begin
      passCount++;
    end else begin
      failCount++;
    end
    $display("segment %0d (%0d,%0d)-(%0d,%0d): %0d pixels, %s", doneSegs, s.startX, s.startY,
             s.endX, s.endY, gotQ.size(), (errs == 0) ? "ok" : "bad");
    gotQ.delete();
  endtask

  always @(posedge clk) begin
    if (rst) begin
      cycleNo = 0;
      // Pulse launched on clock nmiDiv shows up one clock later
      lastNmi = 1;
    end else begin
      cycleNo++;
      if (cycleNo == 1 && (pixelValid || lineDone || nmi || queueFull)) begin
        $display("outputs not idle on the first clock after reset");
        failCount++;
      end
      if (nmi) begin
        failCount += compareValue("nmi spacing", nmiDiv, cycleNo - lastNmi);
        lastNmi = cycleNo;
      end else if (cycleNo - lastNmi >= nmiDiv) begin
        $display("nmi pulse missing %0d clocks after the previous one", nmiDiv);
        failCount++;
        lastNmi = cycleNo;
      end
      if (pixelValid) begin
        if (segQ.size() == 0) begin
          $display("pixel written with no segment pending");
          failCount++;
        end
        gotQ.push_back(pixelOut);
      end
      if (lineDone) begin
        if (segQ.size() == 0) begin
          $display("lineDone with no segment pending");
          failCount++;
        end else begin
          checkSegment(segQ.pop_front(), expQ.pop_front(), pixelValid);
        end
      end
      // Only writes that find room count as accepted
      if (lrWrite && !queueFull) begin
        segQ.push_back(segIn);
        expQ.push_back(expPixels);
      end
      pendingSegs = segQ.size();
    end
  end

endmodule

/* testbench/vectorTb.sv */
module vectorTb;

  localparam int clkDiv        = 8;
  localparam int nmiDiv        = 224;
  localparam int queueDepth    = 4;
  localparam int numEntries    = 20;
  // The fifth write of the burst finds the queue full
  localparam int droppedWrites = 1;
  localparam int waitLimit     = 20000;

  typedef struct packed {
    vectorPkg::lineSeg seg;
    logic              waitFull;
    int                expPixels;
  } stimEntry;

  logic                 clk;
  logic                 rst;
  logic                 lrWrite;
  vectorPkg::lineSeg    segIn;
  int                   expPixels;
  logic                 queueFull;
  logic                 pixelValid;
  logic                 lineDone;
  logic                 nmi;
  vectorPkg::pixelWrite pixelOut;
  int                   passCount;
  int                   failCount;
  int                   doneSegs;
  int                   pendingSegs;
  stimEntry             stimTable [numEntries];
  logic [31:0]          rngState;
  logic                 timedOut;
  int                   totalFails;

  vectorTop #(
    .clkDiv     (clkDiv),
    .nmiDiv     (nmiDiv),
    .queueDepth (queueDepth)
  ) vectorTop_inst (
    .clk        (clk),
    .rst        (rst),
    .lrWrite    (lrWrite),
    .segIn      (segIn),
    .queueFull  (queueFull),
    .pixelValid (pixelValid),
    .lineDone   (lineDone),
    .nmi        (nmi),
    .pixelOut   (pixelOut)
  );

  vectorChecker #(
    .nmiDiv (nmiDiv)
  ) vectorChecker_inst (
    .clk         (clk),
    .rst         (rst),
    .lrWrite     (lrWrite),
    .segIn       (segIn),
    .expPixels   (expPixels),
    .queueFull   (queueFull),
    .pixelValid  (pixelValid),
    .pixelOut    (pixelOut),
    .lineDone    (lineDone),
    .nmi         (nmi),
    .passCount   (passCount),
    .failCount   (failCount),
    .doneSegs    (doneSegs),
    .pendingSegs (pendingSegs)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic stimEntry makeEntry(int x0, int y0, int x1, int y1, int color,
                                         int waitFull, int expCount);
    stimEntry e;
    e.seg.startX  = vectorPkg::coordT'(x0);
    e.seg.startY  = vectorPkg::coordT'(y0);
    e.seg.endX    = vectorPkg::coordT'(x1);
    e.seg.endY    = vectorPkg::coordT'(y1);
    e.seg.intensity = 4'(color);
    e.waitFull    = (waitFull != 0);
    e.expPixels   = expCount;
    return e;
  endfunction

  // Xorshift step with the result in [-pad, span - pad)
  function automatic int randomCoord(int span, int pad);
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return int'(rngState % span) - pad;
  endfunction

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  task automatic buildTable;
    int c [5];
    stimTable[0]  = makeEntry(10, 20, 30, 20, 5, 1, 21);
    stimTable[1]  = makeEntry(50, 100, 50, 60, 7, 1, 41);
    stimTable[2]  = makeEntry(0, 0, 15, 15, 9, 1, 16);
    stimTable[3]  = makeEntry(200, 300, 190, 310, 3, 1, 11);
    stimTable[4]  = makeEntry(0, 0, 9, 3, 12, 1, 10);
    stimTable[5]  = makeEntry(20, 20, 22, 30, 14, 1, 11);
    // Edge crossings and fully hidden vectors
    stimTable[6]  = makeEntry(-5, 10, 5, 10, 2, 1, 6);
    stimTable[7]  = makeEntry(100, 470, 100, 490, 4, 1, 10);
    stimTable[8]  = makeEntry(-20, -20, -10, -15, 6, 1, 0);
    stimTable[9]  = makeEntry(700, 10, 720, 30, 8, 1, 0);
    stimTable[10] = makeEntry(320, 240, 320, 240, 15, 1, 1);
    stimTable[11] = makeEntry(-1, 5, -1, 5, 1, 1, 0);
    // Long vector keeps the rasterizer busy through the burst
    stimTable[12] = makeEntry(100, 400, 160, 400, 11, 0, 61);
    stimTable[13] = makeEntry(600, 0, 639, 0, 10, 0, 40);
    stimTable[14] = makeEntry(639, 0, 639, 20, 9, 0, 21);
    stimTable[15] = makeEntry(630, 479, 639, 470, 8, 0, 10);
    stimTable[16] = makeEntry(0, 479, 5, 479, 7, 0, 6);
    stimTable[17] = makeEntry(1, 1, 2, 2, 6, 0, 2);
    for (int i = 18; i < numEntries; i++) begin
      c[0] = randomCoord(700, 30);
      c[1] = randomCoord(520, 20);
      c[2] = randomCoord(700, 30);
      c[3] = randomCoord(520, 20);
      c[4] = randomCoord(16, 0);
      // Pixel count left to the reference model
      stimTable[i] = makeEntry(c[0], c[1], c[2], c[3], c[4], 1, -1);
    end
  endtask

  task automatic writeSegment(input vectorPkg::lineSeg seg, input int expCount);
    lrWrite   = 1'b1;
    segIn     = seg;
    expPixels = expCount;
    @(negedge clk);
    lrWrite = 1'b0;
  endtask

  task automatic waitFullClear;
    int cycles;
    cycles = 0;
    while (queueFull && cycles < waitLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (queueFull) begin
      $display("timed out waiting for queueFull to clear");
      timedOut = 1'b1;
    end
  endtask

  task automatic waitLineDone;
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!lineDone && cycles < waitLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (!lineDone) begin
      $display("timed out waiting for lineDone");
      timedOut = 1'b1;
    end else begin
      // One more clock so the checker retires the segment
      @(negedge clk);
    end
  endtask

  task automatic drainSegments;
    while (!timedOut && pendingSegs != 0) begin
      waitLineDone();
    end
  endtask

  // Waited entries are also drawn to completion before the next one
  task automatic applyEntry(input stimEntry e);
    if (e.waitFull) begin
      waitFullClear();
    end
    if (!timedOut) begin
      writeSegment(e.seg, e.expPixels);
      if (e.waitFull) begin
        drainSegments();
      end
    end
  endtask

  initial begin
    rst       = 1'b1;
    lrWrite   = 1'b0;
    segIn     = '0;
    expPixels = 0;
    timedOut  = 1'b0;
    rngState  = 32'd39;
    buildTable();
    repeat (10) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < numEntries; i++) begin
      if (!timedOut) begin
        applyEntry(stimTable[i]);
      end
    end
    if (!timedOut) begin
      drainSegments();
    end
    totalFails = failCount + vectorTop_inst.topChecks.assertFails + int'(timedOut);
    if (doneSegs != numEntries - droppedWrites) begin
      $display("mismatch time=%0t signal=doneSegs expected=%0d got=%0d",
               $time, numEntries - droppedWrites, doneSegs);
      totalFails++;
    end
    $display("passed %0d failed %0d", passCount, totalFails);
    if (totalFails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* testbench/vectorTop_chk.sv */
module vectorTopChk (
  input logic                 clk,
  input logic                 rst,
  input logic                 lineDone,
  input logic                 pixelValid,
  input vectorPkg::pixelWrite pixelOut,
  input logic                 queueFull,
  input logic                 queueWrite,
  input logic                 queueRead,
  input logic                 rastState
);

  int doneFails;
  int pixelFails;
  int writeFails;
  int assertFails;

  assign assertFails = doneFails + pixelFails + writeFails;

  // Zero encodes the idle state
  doneWhileBusy: assert property (@(posedge clk) disable iff (rst)
    lineDone |-> (rastState != 1'b0))
    else begin
      $error("lineDone high while the rasterizer is idle");
      doneFails++;
    end

  pixelOnScreen: assert property (@(posedge clk) disable iff (rst)
    pixelValid |-> (int'(pixelOut.x) >= 0) && (int'(pixelOut.x) < vectorPkg::screenW) &&
                   (int'(pixelOut.y) >= 0) && (int'(pixelOut.y) < vectorPkg::screenH))
    else begin
      $error("pixelValid with an off-screen coordinate");
      pixelFails++;
    end

  // A write that finds the queue full and no pull leaves it full
  noWriteWhenFull: assert property (@(posedge clk) disable iff (rst)
    queueFull && queueWrite && !queueRead |=> queueFull)
    else begin
      $error("queue accepted a write while full");
      writeFails++;
    end

endmodule

bind vectorTop vectorTopChk topChecks (
  .clk        (clk),
  .rst        (rst),
  .lineDone   (lineDone),
  .pixelValid (pixelValid),
  .pixelOut   (pixelOut),
  .queueFull  (queueFull),
  .queueWrite (lrWrite),
  .queueRead  (queueRead),
  .rastState  (lineRasterizer_inst.state)
);
